/* hdl/xbar_pkg.sv */
`default_nettype none

package xbar_pkg;

  // crossbar dimensions
  localparam int NUM_IN  = 4;
  localparam int NUM_OUT = 4;

  // field widths of one flit
  localparam int DEST_W    = 2;
  localparam int PAYLOAD_W = 16;

  // destination id, selects one output
  typedef logic [DEST_W-1:0] dest_t;

  // data that survives the crossbar
  typedef logic [PAYLOAD_W-1:0] payload_t;

  // dest sits in the low bits, payload above it
  typedef struct packed {
    payload_t payload;
    dest_t    dest;
  } flit_t;

endpackage

`default_nettype wire

/* hdl/xbar_in_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module xbar_in_fifo
  import xbar_pkg::*;
#(
  parameter int FIFO_DEPTH = 2,
  parameter bit USE_CREDIT = 1'b0
) (
  input  logic  clk_i,
  input  logic  rst_i,

  // upstream side
  input  logic  valid_i,
  input  flit_t flit_i,
  output logic  credit_ready_o,

  // head of queue toward the control
  output logic  head_valid_o,
  output flit_t head_flit_o,
  input  logic  deq_i
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  flit_t            mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  // wrap at the last entry, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full  = (count_q == CNT_W'(FIFO_DEPTH));
  assign wr_en = valid_i && !full;
  assign rd_en = deq_i && head_valid_o;

  assign head_valid_o = (count_q != '0);
  assign head_flit_o  = mem_q[rd_ptr_q];

  // storage
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= flit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (rd_en) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // flow control toward the sender
  if (USE_CREDIT) begin : g_credit
    logic credit_q;

    // one pulse per popped flit, a cycle late
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        credit_q <= 1'b0;
      end else begin
        credit_q <= rd_en;
      end
    end

    assign credit_ready_o = credit_q;
  end else begin : g_ready
    // plain level, no same-cycle dequeue lookahead
    assign credit_ready_o = !full;
  end

endmodule

`default_nettype wire

/* hdl/xbar_rr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module xbar_rr_arbiter #(
  parameter int N = 4
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic [N-1:0] req_i,
  output logic [N-1:0] grant_o,
  input  logic         advance_i
);

  localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

  // highest priority index
  logic [PTR_W-1:0] ptr_q;
  logic [PTR_W-1:0] grant_idx;

  // first requester at or after the pointer, wrapping around
  always_comb begin
    int   idx;
    logic found;
    grant_o   = '0;
    grant_idx = '0;
    found     = 1'b0;
    for (int k = 0; k < N; k++) begin
      idx = (int'(ptr_q) + k) % N;
      if (!found && req_i[idx]) begin
        found        = 1'b1;
        grant_o[idx] = 1'b1;
        grant_idx    = PTR_W'(idx);
      end
    end
  end

  // pointer moves past the winner only when it was served
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (advance_i) begin
      if (grant_idx == PTR_W'(N - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= grant_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/xbar_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module xbar_ctrl
  import xbar_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_i,

  // head state of every input queue
  input  logic  [NUM_IN-1:0]              head_valid_i,
  input  dest_t [NUM_IN-1:0]              head_dest_i,
  output logic  [NUM_IN-1:0]              deq_o,

  // output handshake
  input  logic  [NUM_OUT-1:0]             out_ready_i,
  output logic  [NUM_OUT-1:0]             out_valid_o,
  output logic  [NUM_OUT-1:0][NUM_IN-1:0] grant_o
);

  // row j lists the inputs whose head wants output j
  logic [NUM_OUT-1:0][NUM_IN-1:0] req;
  logic [NUM_OUT-1:0]             xfer;

  // destination decode
  always_comb begin
    for (int j = 0; j < NUM_OUT; j++) begin
      for (int i = 0; i < NUM_IN; i++) begin
        req[j][i] = head_valid_i[i] && (head_dest_i[i] == dest_t'(j));
      end
    end
  end

  // one arbiter per output
  for (genvar j = 0; j < NUM_OUT; j++) begin : g_out
    xbar_rr_arbiter #(
      .N(NUM_IN)
    ) arb_i (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .req_i     (req[j]),
      .grant_o   (grant_o[j]),
      .advance_i (xfer[j])
    );

    assign out_valid_o[j] = |grant_o[j];

    // flit leaves output j this edge
    assign xfer[j] = out_valid_o[j] && out_ready_i[j];
  end

  // pop the served head
  // each input targets a single output, so one term at most
  always_comb begin
    deq_o = '0;
    for (int i = 0; i < NUM_IN; i++) begin
      for (int j = 0; j < NUM_OUT; j++) begin
        deq_o[i] = deq_o[i] | (grant_o[j][i] & xfer[j]);
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/xbar_out_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module xbar_out_mux
  import xbar_pkg::*;
(
  input  flit_t    [NUM_IN-1:0]              head_flit_i,
  input  logic     [NUM_OUT-1:0][NUM_IN-1:0] grant_i,
  output payload_t [NUM_OUT-1:0]             out_data_o
);

  // and-or select, dest bits never reach the output
  always_comb begin
    out_data_o = '0;
    for (int j = 0; j < NUM_OUT; j++) begin
      for (int i = 0; i < NUM_IN; i++) begin
        out_data_o[j] = out_data_o[j]
                      | (head_flit_i[i].payload & {PAYLOAD_W{grant_i[j][i]}});
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/router_crossbar.sv */
`timescale 1ns/1ps
`default_nettype none

module router_crossbar
  import xbar_pkg::*;
#(
  parameter int               FIFO_DEPTH  = 2,
  parameter logic [NUM_IN-1:0] USE_CREDITS = 4'b0011
) (
  input  logic                 clk_i,
  input  logic                 rst_i,

  // input ports
  input  logic     [NUM_IN-1:0]  in_valid_i,
  input  flit_t    [NUM_IN-1:0]  in_flit_i,
  output logic     [NUM_IN-1:0]  in_credit_ready_o,

  // output ports
  output logic     [NUM_OUT-1:0] out_valid_o,
  output payload_t [NUM_OUT-1:0] out_data_o,
  input  logic     [NUM_OUT-1:0] out_ready_i
);

  logic  [NUM_IN-1:0]              head_valid;
  flit_t [NUM_IN-1:0]              head_flit;
  dest_t [NUM_IN-1:0]              head_dest;
  logic  [NUM_IN-1:0]              deq;
  logic  [NUM_OUT-1:0][NUM_IN-1:0] grant;

  // per-input queues, credit or ready chosen per port
  for (genvar i = 0; i < NUM_IN; i++) begin : g_in
    xbar_in_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .USE_CREDIT (USE_CREDITS[i])
    ) fifo_i (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .valid_i        (in_valid_i[i]),
      .flit_i         (in_flit_i[i]),
      .credit_ready_o (in_credit_ready_o[i]),
      .head_valid_o   (head_valid[i]),
      .head_flit_o    (head_flit[i]),
      .deq_i          (deq[i])
    );

    assign head_dest[i] = head_flit[i].dest;
  end

  xbar_ctrl ctrl_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .head_valid_i (head_valid),
    .head_dest_i  (head_dest),
    .deq_o        (deq),
    .out_ready_i  (out_ready_i),
    .out_valid_o  (out_valid_o),
    .grant_o      (grant)
  );

  xbar_out_mux mux_i (
    .head_flit_i (head_flit),
    .grant_i     (grant),
    .out_data_o  (out_data_o)
  );

endmodule

`default_nettype wire

/* dv/router_crossbar_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module router_crossbar_tb
  import xbar_pkg::*;
;

  // mirrors the default parameters of the DUT
  localparam int                FIFO_DEPTH   = 2;
  localparam logic [NUM_IN-1:0] CREDIT_MODE  = 4'b0011;
  localparam int                SEQ_W        = PAYLOAD_W - 2;
  localparam int                FLITS_PER_IN = 150;
  localparam int                FILL_LIMIT   = 200;
  localparam int                RUN_LIMIT    = 20000;
  localparam int                DRAIN_LIMIT  = 2000;

  // where a flit should leave and what it should carry
  typedef struct packed {
    dest_t    port;
    payload_t data;
  } route_t;

  logic                     clk_i;
  logic                     rst_i;
  logic     [NUM_IN-1:0]    in_valid_i;
  flit_t    [NUM_IN-1:0]    in_flit_i;
  logic     [NUM_IN-1:0]    in_credit_ready_o;
  logic     [NUM_OUT-1:0]   out_valid_o;
  payload_t [NUM_OUT-1:0]   out_data_o;
  logic     [NUM_OUT-1:0]   out_ready_i;

  logic [31:0]      lfsr_q;
  payload_t         exp_q [NUM_IN*NUM_OUT][$];
  int               rr_src [$];
  logic [SEQ_W-1:0] seq [NUM_IN];
  int               quota [NUM_IN];
  int               credits [NUM_IN];
  int               pulses [NUM_IN];
  int               delivered [NUM_IN];
  logic             rand_valid;
  logic             rand_ready;
  logic             use_fixed_dest;
  logic             rr_log;
  int               timeout;

  router_crossbar router_crossbar_i (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .in_valid_i        (in_valid_i),
    .in_flit_i         (in_flit_i),
    .in_credit_ready_o (in_credit_ready_o),
    .out_valid_o       (out_valid_o),
    .out_data_o        (out_data_o),
    .out_ready_i       (out_ready_i)
  );

  always #20 clk_i = ~clk_i;

  task automatic abort_run(input string what);
    $display("%s at time %0t", what, $time);
    $display("Simulation FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] time=%0t %s expected=0x%0h actual=0x%0h",
               $time, name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // header selects the output and only the payload survives
  function automatic route_t expected_route(input flit_t f);
    route_t r;
    r.port = f.dest;
    r.data = f.payload;
    return r;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int q = 0; q < NUM_IN*NUM_OUT; q++) begin
      n += exp_q[q].size();
    end
    return n;
  endfunction

  function automatic int remaining();
    int n;
    n = 0;
    for (int i = 0; i < NUM_IN; i++) begin
      n += quota[i];
    end
    return n;
  endfunction

  // per-input sender models driven on the falling edge
  task automatic drive_inputs();
    flit_t  f;
    route_t r;
    logic   go;
    for (int i = 0; i < NUM_IN; i++) begin
      in_valid_i[i] = 1'b0;
      go = (quota[i] > 0);
      if (go && rand_valid) begin
        go = lfsr_bit();
      end
      if (CREDIT_MODE[i]) begin
        go = go && (credits[i] > 0);
      end else begin
        go = go && in_credit_ready_o[i];
      end
      if (go) begin
        f.dest    = use_fixed_dest ? dest_t'(0) : dest_t'(rand_bits(DEST_W));
        f.payload = {i[1:0], seq[i]};
        r         = expected_route(f);
        exp_q[i*NUM_OUT + int'(r.port)].push_back(r.data);
        in_flit_i[i]  = f;
        in_valid_i[i] = 1'b1;
        seq[i]        = seq[i] + 1'b1;
        quota[i]--;
        if (CREDIT_MODE[i]) begin
          credits[i]--;
        end
      end
    end
    if (rand_ready) begin
      out_ready_i = NUM_OUT'(rand_bits(NUM_OUT));
    end
  endtask

  // scoreboard, credit return and round-robin log
  always @(posedge clk_i) begin : compare
    int       src;
    int       qi;
    payload_t expd;
    if (!rst_i) begin
      for (int i = 0; i < NUM_IN; i++) begin
        if (CREDIT_MODE[i] && in_credit_ready_o[i]) begin
          credits[i]++;
          pulses[i]++;
        end
      end
      for (int j = 0; j < NUM_OUT; j++) begin
        if (out_valid_o[j] && out_ready_i[j]) begin
          src = int'(out_data_o[j][PAYLOAD_W-1 -: 2]);
          qi  = src*NUM_OUT + j;
          if (exp_q[qi].size() == 0) begin
            abort_run($sformatf(
              "output %0d delivered a flit from input %0d that was not expected",
              j, src));
          end else begin
            expd = exp_q[qi].pop_front();
            check_value($sformatf("out_data_o[%0d]", j), 32'(expd), 32'(out_data_o[j]));
            delivered[src]++;
            if (j == 0 && rr_log) begin
              rr_src.push_back(src);
            end
          end
        end
      end
    end
  end

  initial begin
    clk_i          = 1'b0;
    rst_i          = 1'b1;
    in_valid_i     = '0;
    in_flit_i      = '0;
    out_ready_i    = '0;
    lfsr_q         = 32'h0a86_3e8e;
    rand_valid     = 1'b0;
    rand_ready     = 1'b0;
    use_fixed_dest = 1'b0;
    rr_log         = 1'b0;
    for (int i = 0; i < NUM_IN; i++) begin
      seq[i]       = '0;
      quota[i]     = 0;
      credits[i]   = FIFO_DEPTH;
      pulses[i]    = 0;
      delivered[i] = 0;
    end

    repeat (16) @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    check_value("out_valid_o", 32'(0), 32'(out_valid_o));
    check_value("in_credit_ready_o", 32'(NUM_IN'(~CREDIT_MODE)), 32'(in_credit_ready_o));

    // fill every input with flits for output 0 while it is stalled
    use_fixed_dest = 1'b1;
    for (int i = 0; i < NUM_IN; i++) begin
      quota[i] = FIFO_DEPTH;
    end
    timeout = 0;
    while (remaining() > 0) begin
      @(negedge clk_i);
      drive_inputs();
      timeout++;
      if (timeout > FILL_LIMIT) begin
        abort_run("input FIFOs did not accept the fill flits in time");
      end
    end
    @(negedge clk_i);
    drive_inputs();
    for (int i = 0; i < NUM_IN; i++) begin
      if (!CREDIT_MODE[i]) begin
        check_value($sformatf("in_credit_ready_o[%0d]", i), 32'(0),
                    32'(in_credit_ready_o[i]));
      end
    end

    // output 0 must hold its head while stalled
    repeat (8) begin
      @(negedge clk_i);
      drive_inputs();
      check_value("out_valid_o[0]", 32'(1), 32'(out_valid_o[0]));
      check_value("out_data_o[0]", 32'(exp_q[0][0]), 32'(out_data_o[0]));
    end

    rr_log         = 1'b1;
    out_ready_i[0] = 1'b1;
    timeout        = 0;
    while (rr_src.size() < NUM_IN*FIFO_DEPTH) begin
      @(negedge clk_i);
      drive_inputs();
      timeout++;
      if (timeout > FILL_LIMIT) begin
        abort_run("round-robin drain of output 0 did not finish");
      end
    end
    rr_log = 1'b0;
    for (int k = 0; k < NUM_IN*FIFO_DEPTH; k++) begin
      check_value($sformatf("source of transfer %0d on output 0", k), 32'(k % NUM_IN),
                  32'(rr_src[k]));
    end

    // random traffic under random back-pressure
    use_fixed_dest = 1'b0;
    rand_valid     = 1'b1;
    rand_ready     = 1'b1;
    for (int i = 0; i < NUM_IN; i++) begin
      quota[i] = FLITS_PER_IN;
    end
    timeout = 0;
    while (remaining() > 0) begin
      @(negedge clk_i);
      drive_inputs();
      timeout++;
      if (timeout > RUN_LIMIT) begin
        abort_run("senders could not place all random flits");
      end
    end

    rand_ready  = 1'b0;
    out_ready_i = '1;
    timeout     = 0;
    while (pending() > 0) begin
      @(negedge clk_i);
      drive_inputs();
      timeout++;
      if (timeout > DRAIN_LIMIT) begin
        abort_run($sformatf("%0d flits never left the crossbar", pending()));
      end
    end
    repeat (3) begin
      @(negedge clk_i);
      drive_inputs();
    end

    check_value("out_valid_o", 32'(0), 32'(out_valid_o));
    for (int i = 0; i < NUM_IN; i++) begin
      if (CREDIT_MODE[i]) begin
        check_value($sformatf("credit pulses of input %0d", i), 32'(delivered[i]),
                    32'(pulses[i]));
        check_value($sformatf("credit count of input %0d", i), 32'(FIFO_DEPTH),
                    32'(credits[i]));
      end
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* router_crossbar.f */
hdl/xbar_pkg.sv
hdl/xbar_in_fifo.sv
hdl/xbar_rr_arbiter.sv
hdl/xbar_ctrl.sv
hdl/xbar_out_mux.sv
hdl/router_crossbar.sv
dv/router_crossbar_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the crossbar testbench with verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing -Wno-fatal \
  --top-module router_crossbar_tb \
  -Mdir "$OBJ" \
  -f router_crossbar.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$OBJ/Vrouter_crossbar_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides the verdict
if grep -q "Simulation PASSED" "$LOG"; then
  echo "run_sim: pass"
  exit 0
else
  echo "run_sim: no pass line in $LOG"
  exit 1
fi
